// ==== Makefile ====
# Verilator build and run of the receive dequeue testbench

VERILATOR ?= verilator
TOP       ?= tb_rx_dequeue
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM) dequeue_cases.txt
	$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== block_counter.sv ====
//////////////////////////////////////////////////
// Block position counter
// Tracks which frame block sits at the front and
// flags the last one
//////////////////////////////////////////////////

module block_counter
  import link_cfg_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  // Restart at block 0 when a frame loads
  input  logic clear_i,
  // One step per shift of the register
  input  logic step_i,
  // Front block is the last of its frame
  output logic last_o
);

  logic [BLOCK_IDX_W-1:0] idx_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      idx_q <= '0;
    end else if (clear_i) begin
      // Clear takes priority, a load never shifts
      idx_q <= '0;
    end else if (step_i) begin
      // Wraps back to zero once the last block is consumed
      idx_q <= idx_q + 1'b1;
    end
  end

  // Last position ends the frame in the FSM
  assign last_o = (idx_q == BLOCK_IDX_W'(NUM_BLOCKS - 1));

endmodule

// ==== block_shift_reg.sv ====
//////////////////////////////////////////////////
// Block shift register
// Loads a frame, shifts it toward the front block
// by block and strips the start bits for output
//////////////////////////////////////////////////

module block_shift_reg
  import link_cfg_pkg::*;
  import link_types_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Control from the dequeue FSM
  input  logic                  load_i,
  input  logic                  shift_i,
  // Incoming frame, taken whole on a load
  input  dq_frame_t             frame_i,
  // Start bit of block 0
  output logic                  front_start_o,
  // All payload bytes, start bits removed
  output logic [MSG_DATA_W-1:0] data_o
);

  // Stored blocks, index 0 is the front
  dq_frame_t blocks_q;
  dq_frame_t blocks_d;

  //////////////////////////////////////////////////
  // Load or shift
  //////////////////////////////////////////////////

  always_comb begin : next_blocks
    // Hold by default, e.g. under output back-pressure
    blocks_d = blocks_q;
    if (load_i) begin
      // A load wins over a shift in the same cycle
      blocks_d = frame_i;
    end else if (shift_i) begin
      // Every block moves one place toward the front
      for (int i = 0; i < NUM_BLOCKS - 1; i++) begin
        blocks_d[i] = blocks_q[i+1];
      end
      // Empty block enters at the back
      blocks_d[NUM_BLOCKS-1] = dq_block_t'({BLOCK_W{1'b0}});
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // Empty register, no start bit visible at the front
      blocks_q <= '0;
    end else begin
      blocks_q <= blocks_d;
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  // Front start bit decides whether a message is offered
  assign front_start_o = blocks_q[0].start;

  always_comb begin : strip_start_bits
    // Block i byte lands in byte lane i of the message
    for (int i = 0; i < NUM_BLOCKS; i++) begin
      data_o[i*BLOCK_DATA_W +: BLOCK_DATA_W] = blocks_q[i].data;
    end
  end

endmodule

// ==== dequeue_cases.txt ====
// Word: 9 hex digits of frame (block 3 down to block 0, 9 bits each, start bit in LSB)
// then 2 hex digits of ready pattern, bit 0 applied first and rotating
4499C8A23FF  // four messages, no back-pressure
DDE66EF5555  // four messages, alternating ready
782B0D024FF  // no start bits
FF40004B53C  // one message from block 0, ready delayed
9C8180802FF  // one message from the last block
EF5F6B7BC96  // messages from blocks 1 and 2
FF807FE0101  // four messages, ready once in eight cycles
00000000000  // empty frame
109010101FF  // messages from blocks 0 and 3
0481C0A03FF  // four messages, no back-pressure

// ==== filelist.f ====
link_cfg_pkg.sv
link_types_pkg.sv
block_counter.sv
block_shift_reg.sv
rx_dequeue_fsm.sv
rx_dequeue_top.sv
rx_dequeue_checker.sv
tb_rx_dequeue.sv

// ==== link_cfg_pkg.sv ====
//////////////////////////////////////////////////
// Link sizing constants
// Block, frame and counter widths shared by the
// receive dequeue path
//////////////////////////////////////////////////

package link_cfg_pkg;

  //////////////////////////////////////////////////
  // Block geometry
  //////////////////////////////////////////////////

  // Payload byte carried by every block
  localparam int BLOCK_DATA_W = 8;
  // Payload plus the message start bit in the LSB
  localparam int BLOCK_W      = BLOCK_DATA_W + 1;

  //////////////////////////////////////////////////
  // Frame and message geometry
  //////////////////////////////////////////////////

  localparam int NUM_BLOCKS   = 4;
  // Start bits removed, only the payload bytes remain
  localparam int MSG_DATA_W   = NUM_BLOCKS * BLOCK_DATA_W;
  // Wide enough to index every block of a frame
  localparam int BLOCK_IDX_W  = $clog2(NUM_BLOCKS);

endpackage

// ==== link_types_pkg.sv ====
//////////////////////////////////////////////////
// Link data types
// Packed block, frame and message layouts used on
// the dequeue ports and inside the shift register
//////////////////////////////////////////////////

package link_types_pkg;

  import link_cfg_pkg::*;

  //////////////////////////////////////////////////
  // One serial block
  //////////////////////////////////////////////////

  // Data byte on top, start bit in the least significant position
  typedef struct packed {
    logic [BLOCK_DATA_W-1:0] data;
    logic                    start;
  } dq_block_t;

  //////////////////////////////////////////////////
  // Full frame
  //////////////////////////////////////////////////

  // Index 0 is the front block, the first to be examined
  // Sits in the lowest bits of the packed frame
  typedef dq_block_t [NUM_BLOCKS-1:0] dq_frame_t;

  //////////////////////////////////////////////////
  // Outgoing message
  //////////////////////////////////////////////////

  // First marks the first message taken from a frame
  // Data has front block byte in the lowest byte
  typedef struct packed {
    logic                  first;
    logic [MSG_DATA_W-1:0] data;
  } dq_msg_t;

endpackage

// ==== rx_dequeue_checker.sv ====
//////////////////////////////////////////////////
// Dequeue checker
// Rebuilds the expected messages of each accepted
// frame and compares the DUT ports every cycle
//////////////////////////////////////////////////

module rx_dequeue_checker
  import link_cfg_pkg::*;
  import link_types_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      frame_valid_i,
  input  logic      frame_ready_i,
  input  dq_frame_t frame_i,
  input  logic      msg_valid_i,
  input  logic      msg_ready_i,
  input  dq_msg_t   msg_i,
  output int        tests_done_o,
  output int        errors_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // Model of the frame in flight
  logic                   active;
  logic [NUM_BLOCKS-1:0]  starts;
  logic [MSG_DATA_W-1:0]  bytes;
  logic [BLOCK_IDX_W-1:0] pos;
  logic                   first_taken;
  logic                   consumed;
  logic                   last_block;
  // Previous cycle, for the hold check
  logic                   stalled;
  dq_msg_t                held_msg;
  int                     msg_count;
  int                     exp_count;
  int                     errors_at_load;

  task automatic check_bit(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      $display("[ERROR] %0d ns %s expected %0b actual %0b", $time, name, exp_val, act_val);
      errors_o++;
    end
  endtask

  task automatic check_data(input string name, input logic [MSG_DATA_W-1:0] exp_val,
                            input logic [MSG_DATA_W-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("[ERROR] %0d ns %s expected %h actual %h", $time, name, exp_val, act_val);
      errors_o++;
    end
  endtask

  // Sampled at the falling edge, inputs and outputs are settled there
  always @(negedge clk_i) begin : compare_ports
    if (reset_i) begin
      active       = 1'b0;
      stalled      = 1'b0;
      tests_done_o = 0;
      errors_o     = 0;
    end else begin
      // Message under back-pressure must not move
      if (stalled) begin
        check_bit("msg_o.first (held)", held_msg.first, msg_i.first);
        check_data("msg_o.data (held)", held_msg.data, msg_i.data);
      end
      if (active) begin
        // Front block leaves when skipped or handed over
        consumed   = ~starts[pos] | msg_ready_i;
        last_block = (pos == BLOCK_IDX_W'(NUM_BLOCKS - 1));
        check_bit("msg_valid_o", starts[pos], msg_valid_i);
        // Messages the DUT actually hands over
        if (msg_valid_i && msg_ready_i) begin
          msg_count++;
        end
        if (starts[pos]) begin
          check_bit("msg_o.first", ~first_taken, msg_i.first);
          // Bytes from the front block onward, zeros above
          check_data("msg_o.data", bytes >> (BLOCK_DATA_W * pos), msg_i.data);
          if (msg_ready_i) begin
            first_taken = 1'b1;
          end
        end
        // Room for the next frame only as the last block goes
        check_bit("frame_ready_o", consumed & last_block, frame_ready_i);
        if (consumed && last_block) begin
          active = 1'b0;
          tests_done_o++;
          if (msg_count != exp_count) begin
            $display("[ERROR] %0d ns message count expected %0d actual %0d",
                     $time, exp_count, msg_count);
            errors_o++;
          end
          $display("case %0d: %0d of %0d messages, %0d mismatches", tests_done_o,
                   msg_count, exp_count, errors_o - errors_at_load);
        end else if (consumed) begin
          pos = pos + 1'b1;
        end
      end else begin
        // Empty register, nothing offered
        check_bit("msg_valid_o", 1'b0, msg_valid_i);
        check_bit("frame_ready_o", 1'b1, frame_ready_i);
      end
      stalled  = msg_valid_i & ~msg_ready_i;
      held_msg = msg_i;
      // New frame, possibly in the same cycle as the old one ends
      if (frame_valid_i && frame_ready_i) begin
        active         = 1'b1;
        pos            = '0;
        first_taken    = 1'b0;
        msg_count      = 0;
        exp_count      = 0;
        errors_at_load = errors_o;
        for (int j = 0; j < NUM_BLOCKS; j++) begin
          starts[j] = frame_i[j].start;
          bytes[j*BLOCK_DATA_W +: BLOCK_DATA_W] = frame_i[j].data;
          if (frame_i[j].start) begin
            exp_count++;
          end
        end
      end
    end
  end

endmodule

// ==== rx_dequeue_fsm.sv ====
//////////////////////////////////////////////////
// Receive dequeue control
// Decides load, shift and offer and drives the
// frame and message handshakes
//////////////////////////////////////////////////

module rx_dequeue_fsm (
  input  logic clk_i,
  input  logic reset_i,
  // Frame input handshake
  input  logic frame_valid_i,
  output logic frame_ready_o,
  // Message output handshake
  output logic msg_valid_o,
  input  logic msg_ready_i,
  // Status from the datapath
  input  logic front_start_i,
  input  logic last_i,
  // Datapath control
  output logic load_o,
  output logic shift_o,
  output logic first_o
);

  // EMPTY has nothing stored, HOLD has a frame in progress
  typedef enum logic {
    EMPTY,
    HOLD
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   holding;
  logic   consumed;
  logic   msg_hs;
  logic   first_pending_q;

  //////////////////////////////////////////////////
  // Handshake and consumption
  //////////////////////////////////////////////////

  assign holding  = (state_q == HOLD);
  // Offer only when the front block starts a message
  assign msg_valid_o = holding & front_start_i;
  assign msg_hs   = msg_valid_o & msg_ready_i;
  // Front block leaves this cycle, skipped or handed over
  assign consumed = holding & (~front_start_i | msg_ready_i);

  // Room for a new frame once the last block goes out
  assign frame_ready_o = ~holding | (last_i & consumed);
  assign load_o        = frame_valid_i & frame_ready_o;
  // A load replaces the contents, so no shift with it
  assign shift_o       = consumed & ~load_o;

  //////////////////////////////////////////////////
  // State register
  //////////////////////////////////////////////////

  always_comb begin : next_state
    state_d = state_q;
    if (load_o) begin
      state_d = HOLD;
    end else if (holding && last_i && consumed) begin
      // Last block gone and no frame waiting
      state_d = EMPTY;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // First message flag
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      first_pending_q <= 1'b0;
    end else if (load_o) begin
      // Fresh frame, its first offer gets the flag
      first_pending_q <= 1'b1;
    end else if (msg_hs) begin
      first_pending_q <= 1'b0;
    end
  end

  assign first_o = first_pending_q;

endmodule

// ==== rx_dequeue_top.sv ====
//////////////////////////////////////////////////
// Receive dequeue top level
// Frames in, start-bit delimited messages out
//////////////////////////////////////////////////

module rx_dequeue_top
  import link_cfg_pkg::*;
  import link_types_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  // Frame input port
  input  logic      frame_valid_i,
  output logic      frame_ready_o,
  input  dq_frame_t frame_i,
  // Message output port
  output logic      msg_valid_o,
  input  logic      msg_ready_i,
  output dq_msg_t   msg_o
);

  logic                  load;
  logic                  shift;
  logic                  first;
  logic                  last;
  logic                  front_start;
  logic [MSG_DATA_W-1:0] msg_data;

  // Control and both handshakes
  rx_dequeue_fsm rx_dequeue_fsm_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .frame_valid_i (frame_valid_i),
    .frame_ready_o (frame_ready_o),
    .msg_valid_o   (msg_valid_o),
    .msg_ready_i   (msg_ready_i),
    .front_start_i (front_start),
    .last_i        (last),
    .load_o        (load),
    .shift_o       (shift),
    .first_o       (first)
  );

  // Load doubles as the counter clear
  block_counter block_counter_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .clear_i (load),
    .step_i  (shift),
    .last_o  (last)
  );

  block_shift_reg block_shift_reg_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .load_i        (load),
    .shift_i       (shift),
    .frame_i       (frame_i),
    .front_start_o (front_start),
    .data_o        (msg_data)
  );

  // Pack the outgoing message
  assign msg_o.first = first;
  assign msg_o.data  = msg_data;

endmodule

// ==== tb_rx_dequeue.sv ====
//////////////////////////////////////////////////
// Receive dequeue testbench
// Case-file frames with random idle gaps and
// rotating output back-pressure
//////////////////////////////////////////////////

module tb_rx_dequeue
  import link_types_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS   = 10;
  localparam int CASE_IDX_W  = $clog2(NUM_TESTS);
  localparam int FRAME_W     = $bits(dq_frame_t);
  // Frame on top, ready pattern in the low byte
  localparam int CASE_W      = FRAME_W + 8;
  // Heaviest case needs about 32 cycles plus its gap
  localparam int CYCLE_LIMIT = NUM_TESTS * 40;

  logic                  clk;
  logic                  reset;
  logic                  frame_valid;
  logic                  frame_ready;
  dq_frame_t             frame;
  logic                  msg_valid;
  logic                  msg_ready;
  dq_msg_t               msg;
  logic [CASE_W-1:0]     cases [NUM_TESTS];
  logic [CASE_IDX_W-1:0] case_idx;
  logic [31:0]           lfsr_state;
  // Pattern of the frame in the DUT, and of the one waiting
  logic [7:0]            ready_pattern;
  logic [7:0]            pending_pattern;
  logic [2:0]            pattern_bit;
  logic                  accepted;
  int                    cycle_count;
  int                    tests_done;
  int                    errors;

  rx_dequeue_top rx_dequeue_top_i (
    .clk_i         (clk),
    .reset_i       (reset),
    .frame_valid_i (frame_valid),
    .frame_ready_o (frame_ready),
    .frame_i       (frame),
    .msg_valid_o   (msg_valid),
    .msg_ready_i   (msg_ready),
    .msg_o         (msg)
  );

  rx_dequeue_checker rx_dequeue_checker_i (
    .clk_i         (clk),
    .reset_i       (reset),
    .frame_valid_i (frame_valid),
    .frame_ready_i (frame_ready),
    .frame_i       (frame),
    .msg_valid_i   (msg_valid),
    .msg_ready_i   (msg_ready),
    .msg_i         (msg),
    .tests_done_o  (tests_done),
    .errors_o      (errors)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // Half the frames follow at once, the rest wait 1 to 8 cycles
  task automatic draw_gap(output int gap);
    logic [2:0] len;
    lfsr_state = lfsr_next(lfsr_state);
    gap = 0;
    if (lfsr_state[0]) begin
      for (int i = 0; i < 3; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        len[i] = lfsr_state[0];
      end
      gap = 1 + int'(len);
    end
  endtask

  // One clock, inputs change 1 ns after the edge
  task automatic advance_cycle();
    logic handshake;
    @(negedge clk);
    handshake = frame_valid & frame_ready;
    @(posedge clk);
    #1;
    accepted = handshake;
    if (handshake) begin
      frame_valid   = 1'b0;
      frame         = '0;
      ready_pattern = pending_pattern;
      pattern_bit   = '0;
    end else begin
      pattern_bit = pattern_bit + 1'b1;
    end
    msg_ready = ready_pattern[pattern_bit];
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles with %0d of %0d cases finished",
             cycle_count, tests_done, NUM_TESTS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : stimulus
    int gap;
    reset           = 1'b1;
    frame_valid     = 1'b0;
    frame           = '0;
    msg_ready       = 1'b0;
    ready_pattern   = '0;
    pending_pattern = '0;
    pattern_bit     = '0;
    accepted        = 1'b0;
    lfsr_state      = 32'h693e6052;
    $readmemh("dequeue_cases.txt", cases);
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      draw_gap(gap);
      repeat (gap) advance_cycle();
      case_idx        = CASE_IDX_W'(t);
      frame           = cases[case_idx][CASE_W-1 -: FRAME_W];
      pending_pattern = cases[case_idx][7:0];
      frame_valid     = 1'b1;
      // Valid and data held until the DUT takes the frame
      do begin
        advance_cycle();
      end while (!accepted);
    end
    while (tests_done < NUM_TESTS) begin
      advance_cycle();
    end
    $display("Cases finished %0d of %0d, mismatches %0d", tests_done, NUM_TESTS, errors);
    if (errors == 0 && tests_done == NUM_TESTS) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
